// ==== sim/program_stim.txt ====
# Columns: record type, byte address (hex), word (hex)
# I = instruction, D = initial data word, S = expected store, in program order
# Dependent ALU chain at distances 1, 2 and 3
I 00000000 24010035 # addiu r1, r0, 0x35        r1 = 0x35
I 00000004 24220f0f # addiu r2, r1, 0x0f0f      r2 = 0xf44
I 00000008 00221821 # addu  r3, r1, r2          r3 = 0xf79
I 0000000c 00232023 # subu  r4, r1, r3          r4 = 0xfffff0bc
I 00000010 00822824 # and   r5, r4, r2          r5 = 0x4
I 00000014 00a33025 # or    r6, r5, r3          r6 = 0xf7d
I 00000018 0081382a # slt   r7, r4, r1          r7 = 1
I 0000001c 0024402a # slt   r8, r1, r4          r8 = 0
I 00000020 ac060200 # sw r6, 0x200(r0)
I 00000024 ac070204 # sw r7, 0x204(r0)
I 00000028 ac040208 # sw r4, 0x208(r0)
I 0000002c ac08020c # sw r8, 0x20c(r0)
I 00000030 ac050210 # sw r5, 0x210(r0)
I 00000034 2469ffff # addiu r9, r3, -1          r9 = 0xf78
I 00000038 ac090214 # sw r9, 0x214(r0)
I 0000003c 240a0300 # addiu r10, r0, 0x300
I 00000040 ad420004 # sw r2, 4(r10)
# Load-use
I 00000044 8c0b0100 # lw r11, 0x100(r0)         r11 = 0x1234
I 00000048 256c0010 # addiu r12, r11, 0x10      r12 = 0x1244
I 0000004c ac0c0218 # sw r12, 0x218(r0)
I 00000050 8c0d0104 # lw r13, 0x104(r0)
I 00000054 ac0d021c # sw r13, 0x21c(r0)
# Branches, the stores to 0x2f0, 0x2f4 and 0x2f8 must never happen
I 00000058 10210001 # beq r1, r1, +1            taken
I 0000005c ac0102f0 # sw r1, 0x2f0(r0)
I 00000060 ac010220 # sw r1, 0x220(r0)
I 00000064 14220001 # bne r1, r2, +1            taken
I 00000068 ac0202f4 # sw r2, 0x2f4(r0)
I 0000006c 10220001 # beq r1, r2, +1            not taken
I 00000070 ac020224 # sw r2, 0x224(r0)
I 00000074 8c0e0100 # lw r14, 0x100(r0)
I 00000078 15cb0001 # bne r14, r11, +1          not taken after the stall
I 0000007c ac0e0228 # sw r14, 0x228(r0)
I 00000080 8c0f0104 # lw r15, 0x104(r0)
I 00000084 15e00001 # bne r15, r0, +1           taken after the stall
I 00000088 ac0f02f8 # sw r15, 0x2f8(r0)
I 0000008c ac0f022c # sw r15, 0x22c(r0)
# Register 0
I 00000090 24000055 # addiu r0, r0, 0x55
I 00000094 00220021 # addu  r0, r1, r2
I 00000098 ac000230 # sw r0, 0x230(r0)
I 0000009c 1000ffff # beq r0, r0, -1            park
D 00000100 00001234
D 00000104 80000001
S 00000200 00000f7d
S 00000204 00000001
S 00000208 fffff0bc
S 0000020c 00000000
S 00000210 00000004
S 00000214 00000f78
S 00000304 00000f44
S 00000218 00001244
S 0000021c 80000001
S 00000220 00000035
S 00000224 00000f44
S 00000228 00001234
S 0000022c 80000001
S 00000230 00000000

// ==== sources.f ====
source/cpu_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/register_file.sv
source/hazard_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipeline_cpu.sv
sim/pipeline_cpu_props.sv
sim/tb_pipeline_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_pipeline_cpu
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_pipeline_cpu.sv ====
`timescale 1ns/1ps

module tb_pipeline_cpu import cpu_pkg::*; ();

	localparam word_t RESET_PC      = 32'h0;
	localparam int    MEM_WORDS     = 256;
	localparam int    STORE_TIMEOUT = 2000;
	localparam int    QUIET_CYCLES  = 50;

	logic  clk_i;
	logic  arst_n_i;
	word_t imem_addr_o;
	word_t imem_data_i;
	logic  dmem_en_o;
	logic  dmem_we_o;
	word_t dmem_addr_o;
	word_t dmem_wdata_o;
	word_t dmem_rdata_i;

	word_t imem [MEM_WORDS];
	word_t dmem [MEM_WORDS];
	word_t exp_addr [$];
	word_t exp_data [$];
	int    store_count = 0;

	pipeline_cpu #(
		.RESET_PC (RESET_PC)
	) u_pipeline_cpu (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.imem_addr_o  (imem_addr_o),
		.imem_data_i  (imem_data_i),
		.dmem_en_o    (dmem_en_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

	bind pipeline_cpu pipeline_cpu_props u_pipeline_cpu_props (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.imem_addr_o (imem_addr_o),
		.dmem_en_o   (dmem_en_o),
		.dmem_we_o   (dmem_we_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("ERR %s: got 0x%08h, expected 0x%08h",
				name, actual, expected));
		end
	endtask

	// Records are tag, byte address, word; a lone # starts a comment
	task automatic load_stimulus();
		int               fd;
		int               code;
		logic [7:0]       tag;
		word_t            addr;
		word_t            data;
		logic [8*160-1:0] rest;
		fd = $fopen("sim/program_stim.txt", "r");
		if (fd == 0) begin
			stop_with_failure("Cannot open the stimulus file sim/program_stim.txt");
		end
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h", addr, data);
				if (code != 2) begin
					stop_with_failure("Stimulus file has a record without address and data");
				end
				case (tag)
					"I": imem[addr[9:2]] = data;
					"D": dmem[addr[9:2]] = data;
					"S": begin
						exp_addr.push_back(addr);
						exp_data.push_back(data);
					end
					default: stop_with_failure("Stimulus file has an unknown record type");
				endcase
			end
			code = $fscanf(fd, "%s", tag);
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory models

	// Same-cycle read on both ports
	assign imem_data_i  = imem[imem_addr_o[9:2]];
	assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

	// Outputs are stable mid-cycle, the store lands at the next rising edge
	always @(negedge clk_i) begin
		if (!arst_n_i) begin
			check_value("dmem_en_o", 32'(dmem_en_o), 32'h0);
			check_value("dmem_we_o", 32'(dmem_we_o), 32'h0);
		end else if (dmem_en_o && dmem_we_o) begin
			if (store_count >= exp_addr.size()) begin
				stop_with_failure($sformatf("Unexpected store of 0x%08h to address 0x%08h",
					dmem_wdata_o, dmem_addr_o));
			end else begin
				check_value("dmem_addr_o", dmem_addr_o, exp_addr[store_count]);
				check_value("dmem_wdata_o", dmem_wdata_o, exp_data[store_count]);
				dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
				store_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int cycles;
		arst_n_i = 1'b0;
		// Unused words decode as unsupported opcodes
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = {6'h3f, 26'(i * 4)};
			dmem[i] = 32'hda7a_0000 | 32'(i * 4);
		end
		load_stimulus();

		repeat (3) @(posedge clk_i);
		arst_n_i <= 1'b1;
		@(negedge clk_i);
		check_value("imem_addr_o", imem_addr_o, RESET_PC);

		cycles = 0;
		while (store_count < exp_addr.size()) begin
			@(posedge clk_i);
			cycles++;
			if (cycles > STORE_TIMEOUT) begin
				stop_with_failure($sformatf("Timed out with %0d of %0d stores seen",
					store_count, exp_addr.size()));
			end
		end

		// Program parks in a branch to itself, no more stores allowed
		repeat (QUIET_CYCLES) @(posedge clk_i);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== sim/pipeline_cpu_props.sv ====
`timescale 1ns/1ps

module pipeline_cpu_props import cpu_pkg::*; (
	input logic  clk_i,
	input logic  arst_n_i,
	input word_t imem_addr_o,
	input logic  dmem_en_o,
	input logic  dmem_we_o
);

	// A write is always part of a data port access
	we_needs_en: assert property (
		@(posedge clk_i) disable iff (!arst_n_i) dmem_we_o |-> dmem_en_o
	) else $error("dmem_we_o high while dmem_en_o is low");

	quiet_in_reset: assert property (
		@(posedge clk_i) !arst_n_i |-> (!dmem_en_o && !dmem_we_o)
	) else $error("Data port strobe high during reset");

	// Fetch address word aligned
	pc_aligned: assert property (
		@(posedge clk_i) disable iff (!arst_n_i) imem_addr_o[1:0] == 2'b00
	) else $error("imem_addr_o not word aligned");

endmodule

// ==== source/pipeline_cpu.sv ====
`timescale 1ns/1ps

module pipeline_cpu import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic  clk_i,
	input  logic  arst_n_i,
	output word_t imem_addr_o,
	input  word_t imem_data_i,
	output logic  dmem_en_o,
	output logic  dmem_we_o,
	output word_t dmem_addr_o,
	output word_t dmem_wdata_o,
	input  word_t dmem_rdata_i
);

	word_t     pc;
	logic      stall;
	logic      flush;
	fwd_sel_e  fwd_a_sel;
	fwd_sel_e  fwd_b_sel;
	reg_addr_t rs;
	reg_addr_t rt;
	logic      branch_taken;
	word_t     branch_target;

	id_ex_if  u_id_ex ();
	ex_mem_if u_ex_mem ();
	fwd_if    u_fwd ();

	assign imem_addr_o = pc;

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch_stage (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.stall_i         (stall),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.pc_o            (pc)
	);

	decode_stage u_decode_stage (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.stall_i         (stall),
		.flush_i         (flush),
		.pc_i            (pc),
		.instr_i         (imem_data_i),
		.fwd_a_sel_i     (fwd_a_sel),
		.fwd_b_sel_i     (fwd_b_sel),
		.fwd             (u_fwd),
		.id_ex           (u_id_ex),
		.rs_o            (rs),
		.rt_o            (rt),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target)
	);

	hazard_unit u_hazard_unit (
		.rs_i           (rs),
		.rt_i           (rt),
		.branch_taken_i (branch_taken),
		.fwd            (u_fwd),
		.stall_o        (stall),
		.flush_o        (flush),
		.fwd_a_sel_o    (fwd_a_sel),
		.fwd_b_sel_o    (fwd_b_sel)
	);

	execute_stage u_execute_stage (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.stall_i  (stall),
		.id_ex    (u_id_ex),
		.ex_mem   (u_ex_mem),
		.fwd      (u_fwd)
	);

	memory_stage u_memory_stage (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.ex_mem       (u_ex_mem),
		.fwd          (u_fwd),
		.dmem_en_o    (dmem_en_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
	input  logic         clk_i,
	input  logic         arst_n_i,
	ex_mem_if.dst        ex_mem,
	fwd_if.mem_producer  fwd,
	output logic         dmem_en_o,
	output logic         dmem_we_o,
	output word_t        dmem_addr_o,
	output word_t        dmem_wdata_o,
	input  word_t        dmem_rdata_i
);

	logic      exmem_valid;
	logic      exmem_reg_write;
	logic      exmem_load;
	logic      exmem_store;
	word_t     exmem_result;
	word_t     exmem_store_data;
	reg_addr_t exmem_rd;
	word_t     mem_data;
	logic      wb_reg_write;
	word_t     wb_data;
	reg_addr_t wb_rd;

	////////////////////////////////////////////////////////////////////////////
	// EX/MEM register

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exmem_valid     <= 1'b0;
			exmem_reg_write <= 1'b0;
			exmem_load      <= 1'b0;
			exmem_store     <= 1'b0;
		end else begin
			exmem_valid     <= ex_mem.valid;
			exmem_reg_write <= ex_mem.reg_write;
			exmem_load      <= ex_mem.load;
			exmem_store     <= ex_mem.store;
		end
	end

	always_ff @(posedge clk_i) begin
		exmem_result     <= ex_mem.result;
		exmem_store_data <= ex_mem.store_data;
		exmem_rd         <= ex_mem.rd;
	end

	// Data port, read data comes back in the same cycle
	assign dmem_en_o    = exmem_valid && (exmem_load || exmem_store);
	assign dmem_we_o    = exmem_valid && exmem_store;
	assign dmem_addr_o  = exmem_result;
	assign dmem_wdata_o = exmem_store_data;

	assign mem_data = exmem_load ? dmem_rdata_i : exmem_result;

	////////////////////////////////////////////////////////////////////////////
	// MEM/WB register

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_reg_write <= 1'b0;
		end else begin
			wb_reg_write <= exmem_valid && exmem_reg_write;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_data <= mem_data;
		wb_rd   <= exmem_rd;
	end

	assign fwd.mem_data      = mem_data;
	assign fwd.mem_rd        = exmem_rd;
	assign fwd.mem_reg_write = exmem_valid && exmem_reg_write;
	assign fwd.wb_data       = wb_data;
	assign fwd.wb_rd         = wb_rd;
	assign fwd.wb_reg_write  = wb_reg_write;

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        stall_i,
	id_ex_if.dst        id_ex,
	ex_mem_if.src       ex_mem,
	fwd_if.ex_producer  fwd
);

	logic      idex_valid;
	logic      idex_reg_write;
	logic      idex_load;
	logic      idex_store;
	alu_op_e   idex_alu_op;
	word_t     idex_a;
	word_t     idex_b;
	word_t     idex_imm;
	logic      idex_use_imm;
	reg_addr_t idex_rd;
	word_t     alu_b;
	word_t     alu_result;

	////////////////////////////////////////////////////////////////////////////
	// ID/EX register, a stall inserts a bubble

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			idex_valid     <= 1'b0;
			idex_reg_write <= 1'b0;
			idex_load      <= 1'b0;
			idex_store     <= 1'b0;
		end else if (stall_i) begin
			idex_valid     <= 1'b0;
			idex_reg_write <= 1'b0;
			idex_load      <= 1'b0;
			idex_store     <= 1'b0;
		end else begin
			idex_valid     <= id_ex.valid;
			idex_reg_write <= id_ex.reg_write;
			idex_load      <= id_ex.load;
			idex_store     <= id_ex.store;
		end
	end

	always_ff @(posedge clk_i) begin
		idex_alu_op  <= id_ex.alu_op;
		idex_a       <= id_ex.op_a;
		idex_b       <= id_ex.op_b;
		idex_imm     <= id_ex.imm;
		idex_use_imm <= id_ex.use_imm;
		idex_rd      <= id_ex.rd;
	end

	assign alu_b = idex_use_imm ? idex_imm : idex_b;

	always_comb begin
		case (idex_alu_op)
			ALU_ADD: alu_result = idex_a + alu_b;
			ALU_SUB: alu_result = idex_a - alu_b;
			ALU_AND: alu_result = idex_a & alu_b;
			ALU_OR:  alu_result = idex_a | alu_b;
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, ($signed(idex_a) < $signed(alu_b))};
			default: alu_result = '0;
		endcase
	end

	assign ex_mem.valid      = idex_valid;
	assign ex_mem.result     = alu_result;
	assign ex_mem.store_data = idex_b;
	assign ex_mem.rd         = idex_rd;
	assign ex_mem.reg_write  = idex_reg_write;
	assign ex_mem.load       = idex_load;
	assign ex_mem.store      = idex_store;

	assign fwd.ex_result    = alu_result;
	assign fwd.ex_rd        = idex_rd;
	assign fwd.ex_reg_write = idex_valid && idex_reg_write;
	assign fwd.ex_load      = idex_valid && idex_load;

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
	input  logic      clk_i,
	input  logic      arst_n_i,
	input  logic      stall_i,
	input  logic      flush_i,
	input  word_t     pc_i,
	input  word_t     instr_i,
	input  fwd_sel_e  fwd_a_sel_i,
	input  fwd_sel_e  fwd_b_sel_i,
	fwd_if.consumer   fwd,
	id_ex_if.src      id_ex,
	output reg_addr_t rs_o,
	output reg_addr_t rt_o,
	output logic      branch_taken_o,
	output word_t     branch_target_o
);

	logic      ifid_valid;
	word_t     ifid_pc;
	word_t     ifid_instr;
	opcode_e   opcode;
	funct_e    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm_ext;
	word_t     rs_data;
	word_t     rt_data;
	word_t     op_a;
	word_t     op_b;
	alu_op_e   alu_op;
	logic      use_imm;
	reg_addr_t dest;
	logic      reg_write;
	logic      load;
	logic      store;
	logic      is_beq;
	logic      is_bne;

	////////////////////////////////////////////////////////////////////////////
	// IF/ID register

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ifid_valid <= 1'b0;
			ifid_pc    <= '0;
			ifid_instr <= '0;
		end else if (stall_i) begin
			ifid_valid <= ifid_valid;
		end else if (flush_i) begin
			// Wrong-path fetch after a taken branch
			ifid_valid <= 1'b0;
			ifid_instr <= '0;
		end else begin
			ifid_valid <= 1'b1;
			ifid_pc    <= pc_i;
			ifid_instr <= instr_i;
		end
	end

	assign opcode  = opcode_e'(ifid_instr[31:26]);
	assign funct   = funct_e'(ifid_instr[5:0]);
	assign rs      = ifid_instr[25:21];
	assign rt      = ifid_instr[20:16];
	assign rd      = ifid_instr[15:11];
	assign imm_ext = {{16{ifid_instr[15]}}, ifid_instr[15:0]};

	////////////////////////////////////////////////////////////////////////////
	// Control decode, anything unknown stays a no-op

	always_comb begin
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		dest      = '0;
		reg_write = 1'b0;
		load      = 1'b0;
		store     = 1'b0;
		is_beq    = 1'b0;
		is_bne    = 1'b0;
		if (ifid_valid) begin
			case (opcode)
				OP_SPECIAL: begin
					dest      = rd;
					reg_write = 1'b1;
					case (funct)
						FN_ADDU: alu_op = ALU_ADD;
						FN_SUBU: alu_op = ALU_SUB;
						FN_AND:  alu_op = ALU_AND;
						FN_OR:   alu_op = ALU_OR;
						FN_SLT:  alu_op = ALU_SLT;
						default: reg_write = 1'b0;
					endcase
				end
				OP_ADDIU: begin
					use_imm   = 1'b1;
					dest      = rt;
					reg_write = 1'b1;
				end
				OP_LW: begin
					use_imm   = 1'b1;
					dest      = rt;
					reg_write = 1'b1;
					load      = 1'b1;
				end
				OP_SW: begin
					use_imm = 1'b1;
					store   = 1'b1;
				end
				OP_BEQ:  is_beq = 1'b1;
				OP_BNE:  is_bne = 1'b1;
				default: ;
			endcase
		end
	end

	register_file u_register_file (
		.clk_i     (clk_i),
		.rs_i      (rs),
		.rt_i      (rt),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.we_i      (fwd.wb_reg_write),
		.waddr_i   (fwd.wb_rd),
		.wdata_i   (fwd.wb_data)
	);

	function automatic word_t operand(fwd_sel_e sel, word_t rf, word_t ex, word_t mem,
		word_t wb);
		case (sel)
			FWD_EX:  return ex;
			FWD_MEM: return mem;
			FWD_WB:  return wb;
			default: return rf;
		endcase
	endfunction

	assign op_a = operand(fwd_a_sel_i, rs_data, fwd.ex_result, fwd.mem_data, fwd.wb_data);
	assign op_b = operand(fwd_b_sel_i, rt_data, fwd.ex_result, fwd.mem_data, fwd.wb_data);

	// Branches resolve here, target is pc + 4 + (imm << 2)
	assign branch_taken_o  = (is_beq && (op_a == op_b)) || (is_bne && (op_a != op_b));
	assign branch_target_o = ifid_pc + 32'd4 + {imm_ext[29:0], 2'b00};

	assign rs_o = rs;
	assign rt_o = rt;

	assign id_ex.valid     = ifid_valid;
	assign id_ex.alu_op    = alu_op;
	assign id_ex.op_a      = op_a;
	assign id_ex.op_b      = op_b;
	assign id_ex.imm       = imm_ext;
	assign id_ex.use_imm   = use_imm;
	assign id_ex.rd        = dest;
	assign id_ex.reg_write = reg_write;
	assign id_ex.load      = load;
	assign id_ex.store     = store;

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input  reg_addr_t  rs_i,
	input  reg_addr_t  rt_i,
	input  logic       branch_taken_i,
	fwd_if.monitor     fwd,
	output logic       stall_o,
	output logic       flush_o,
	output fwd_sel_e   fwd_a_sel_o,
	output fwd_sel_e   fwd_b_sel_o
);

	// Youngest producer first, register 0 never forwarded
	function automatic fwd_sel_e pick_source(reg_addr_t src);
		if (src == '0) return FWD_REG;
		if (fwd.ex_reg_write && (fwd.ex_rd == src)) return FWD_EX;
		if (fwd.mem_reg_write && (fwd.mem_rd == src)) return FWD_MEM;
		if (fwd.wb_reg_write && (fwd.wb_rd == src)) return FWD_WB;
		return FWD_REG;
	endfunction

	always_comb begin
		fwd_a_sel_o = pick_source(rs_i);
		fwd_b_sel_o = pick_source(rt_i);
	end

	// Load in execute feeding decode, data only exists one stage later
	assign stall_o = fwd.ex_load && (fwd.ex_rd != '0) &&
		((fwd.ex_rd == rs_i) || (fwd.ex_rd == rt_i));

	assign flush_o = branch_taken_i && !stall_o;

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic      clk_i,
	input  reg_addr_t rs_i,
	input  reg_addr_t rt_i,
	output word_t     rs_data_o,
	output word_t     rt_data_o,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Register 0 reads zero whatever the array holds
	assign rs_data_o = (rs_i == '0) ? '0 : regs[rs_i];
	assign rt_data_o = (rt_i == '0) ? '0 : regs[rt_i];

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic  clk_i,
	input  logic  arst_n_i,
	input  logic  stall_i,
	input  logic  branch_taken_i,
	input  word_t branch_target_i,
	output word_t pc_o
);

	word_t pc;

	// Stall wins over a redirect, the branch is re-resolved afterwards
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc <= RESET_PC;
		end else if (stall_i) begin
			pc <= pc;
		end else if (branch_taken_i) begin
			pc <= branch_target_i;
		end else begin
			pc <= pc + 32'd4;
		end
	end

	assign pc_o = pc;

endmodule

// ==== source/pipe_if.sv ====
`timescale 1ns/1ps

// Decode to execute
interface id_ex_if import cpu_pkg::*; ();
	logic      valid;
	alu_op_e   alu_op;
	word_t     op_a;
	word_t     op_b;
	word_t     imm;
	logic      use_imm;
	reg_addr_t rd;
	logic      reg_write;
	logic      load;
	logic      store;

	modport src (output valid, alu_op, op_a, op_b, imm, use_imm, rd, reg_write, load, store);
	modport dst (input valid, alu_op, op_a, op_b, imm, use_imm, rd, reg_write, load, store);
endinterface

// Execute to memory
interface ex_mem_if import cpu_pkg::*; ();
	logic      valid;
	word_t     result;
	word_t     store_data;
	reg_addr_t rd;
	logic      reg_write;
	logic      load;
	logic      store;

	modport src (output valid, result, store_data, rd, reg_write, load, store);
	modport dst (input valid, result, store_data, rd, reg_write, load, store);
endinterface

// Results travelling back to decode
interface fwd_if import cpu_pkg::*; ();
	word_t     ex_result;
	reg_addr_t ex_rd;
	logic      ex_reg_write;
	logic      ex_load;
	word_t     mem_data;
	reg_addr_t mem_rd;
	logic      mem_reg_write;
	word_t     wb_data;
	reg_addr_t wb_rd;
	logic      wb_reg_write;

	modport ex_producer (output ex_result, ex_rd, ex_reg_write, ex_load);
	modport mem_producer (output mem_data, mem_rd, mem_reg_write, wb_data, wb_rd, wb_reg_write);
	modport consumer (input ex_result, mem_data, wb_data, wb_rd, wb_reg_write);
	modport monitor (input ex_rd, ex_reg_write, ex_load, mem_rd, mem_reg_write,
		wb_rd, wb_reg_write);
endinterface

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	parameter int XLEN       = 32;
	parameter int REG_ADDR_W = 5;
	parameter int NUM_REGS   = 32;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Major opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	// Where a decode operand comes from
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

endpackage
